/* source/oscope_bus_pkg.sv */
// Local bus is 24-bit address, 32-bit data; SPI timing is counted in lb_clk cycles
`default_nettype none

package oscope_bus_pkg;

	localparam int LB_AW = 24;
	localparam int LB_DW = 32;
	localparam int SPI_WORD_W = 16;

	typedef logic [LB_AW-1:0] lb_addr_t;
	typedef logic [LB_DW-1:0] lb_data_t;
	typedef logic [SPI_WORD_W-1:0] spi_word_t;

	// Register map
	localparam lb_addr_t ADDR_CTRL = 24'h000001;      // Bit 0 arms a capture
	localparam lb_addr_t ADDR_STATUS = 24'h000002;    // {ready, done}
	localparam lb_addr_t ADDR_SPI_CMD = 24'h000003;   // {addr, data}, starts a frame
	localparam lb_addr_t ADDR_SPI_RDBK = 24'h000004;

	// Anything with this bit set is a buffer read
	localparam int BUF_WINDOW_BIT = 23;

	// Monitor SPI framing
	localparam int SPI_HALF = 4;        // lb_clk cycles per sclk half period
	localparam int SPI_FRAME_BITS = 32;
	localparam int SPI_HALF_W = $clog2(SPI_HALF);
	localparam int SPI_BIT_W = $clog2(SPI_FRAME_BITS);

endpackage

`default_nettype wire

/* source/oscope_adc_pkg.sv */
// Digitizer word is four 16-bit channels packed low to high; buffer depth is 2**BUF_AW words
`default_nettype none

package oscope_adc_pkg;

	localparam int BUF_AW = 13;
	localparam int CHANNELS = 4;
	localparam int SAMPLE_W = 16;

	typedef logic [SAMPLE_W-1:0] sample_t;

	// Channel 0 sits in bits 15:0
	typedef sample_t [CHANNELS-1:0] adc_word_t;

	typedef logic [BUF_AW-1:0] buf_addr_t;
	typedef logic [$clog2(CHANNELS)-1:0] chan_sel_t;

endpackage

`default_nettype wire

/* source/oscope_ifs.sv */
// Internal links only; start and arm are single-cycle pulses, no handshake back
`default_nettype none

// Register block to monitor SPI master
interface spi_cmd_if;
	logic start;                       // One-cycle pulse
	oscope_bus_pkg::spi_word_t addr;
	oscope_bus_pkg::spi_word_t data;
	logic ready;                       // Level, low while a frame runs
	oscope_bus_pkg::spi_word_t rdbk;

	modport regs (output start, addr, data, input ready, rdbk);
	modport master (input start, addr, data, output ready, rdbk);
endinterface

// Register block to capture buffer
interface capture_if;
	logic arm;                         // One-cycle pulse
	oscope_adc_pkg::buf_addr_t rd_index;
	oscope_adc_pkg::chan_sel_t rd_chan;
	logic done;
	oscope_adc_pkg::sample_t rd_sample; // One cycle after index/chan

	modport regs (output arm, rd_index, rd_chan, input done, rd_sample);
	modport buffer (input arm, rd_index, rd_chan, output done, rd_sample);
endinterface

`default_nettype wire

/* source/lb_regs.sv */
// Read data and lb_rd_valid_o follow a read strobe by two cycles; unmapped reads give 0
`default_nettype none

module lb_regs (
	input logic lb_clk,
	input logic reset_i,
	input oscope_bus_pkg::lb_addr_t lb_addr_i,
	input logic lb_strobe_i,
	input logic lb_rd_i,
	input logic lb_write_i,
	input oscope_bus_pkg::lb_data_t lb_data_i,
	output oscope_bus_pkg::lb_data_t lb_din_o,
	output logic lb_rd_valid_o,
	spi_cmd_if.regs spi,
	capture_if.regs cap
);

	logic wr_accept;
	logic rd_accept;
	logic rd_d1;
	logic sel_buf;
	logic sel_status;
	logic sel_rdbk;

	assign wr_accept = lb_strobe_i & lb_write_i;
	assign rd_accept = lb_strobe_i & lb_rd_i;

	// Buffer address goes straight to the memory so its latency fits stage 1
	assign cap.rd_index = lb_addr_i[oscope_adc_pkg::BUF_AW+1:2];
	assign cap.rd_chan = lb_addr_i[1:0];

	// Command pulses and pipeline valid
	always_ff @(posedge lb_clk) begin
		if (reset_i) begin
			cap.arm <= 1'b0;
			spi.start <= 1'b0;
			rd_d1 <= 1'b0;
			lb_rd_valid_o <= 1'b0;
		end else begin
			cap.arm <= wr_accept && lb_addr_i == oscope_bus_pkg::ADDR_CTRL && lb_data_i[0];
			spi.start <= wr_accept && lb_addr_i == oscope_bus_pkg::ADDR_SPI_CMD;
			rd_d1 <= rd_accept;
			lb_rd_valid_o <= rd_d1;
		end
	end

	// SPI command fields, taken with the start pulse
	always_ff @(posedge lb_clk) begin
		if (wr_accept && lb_addr_i == oscope_bus_pkg::ADDR_SPI_CMD) begin
			spi.addr <= lb_data_i[31:16];
			spi.data <= lb_data_i[15:0];
		end
	end

	// Stage 1 decode
	always_ff @(posedge lb_clk) begin
		sel_buf <= lb_addr_i[oscope_bus_pkg::BUF_WINDOW_BIT];
		sel_status <= lb_addr_i == oscope_bus_pkg::ADDR_STATUS;
		sel_rdbk <= lb_addr_i == oscope_bus_pkg::ADDR_SPI_RDBK;
	end

	// Stage 2 mux
	always_ff @(posedge lb_clk) begin
		if (sel_buf)
			lb_din_o <= oscope_bus_pkg::lb_data_t'(cap.rd_sample);
		else if (sel_status)
			lb_din_o <= oscope_bus_pkg::lb_data_t'({spi.ready, cap.done});
		else if (sel_rdbk)
			lb_din_o <= oscope_bus_pkg::lb_data_t'(spi.rdbk);
		else
			lb_din_o <= '0;
	end

endmodule

`default_nettype wire

/* source/capture_buffer.sv */
// One burst per arm fills the whole buffer; no trigger, no wrap, readout lags one cycle
`default_nettype none

module capture_buffer (
	input logic lb_clk,
	input logic reset_i,
	input oscope_adc_pkg::adc_word_t adc_dout_i,
	capture_if.buffer cap
);

	localparam int DEPTH = 2 ** oscope_adc_pkg::BUF_AW;

	oscope_adc_pkg::adc_word_t mem [DEPTH];
	oscope_adc_pkg::adc_word_t word_q;
	oscope_adc_pkg::chan_sel_t chan_q;
	oscope_adc_pkg::buf_addr_t wr_idx;
	logic active;

	// Write counter and done flag
	always_ff @(posedge lb_clk) begin
		if (reset_i) begin
			active <= 1'b0;
			wr_idx <= '0;
			cap.done <= 1'b0;
		end else if (cap.arm) begin
			// Also restarts a capture in flight
			active <= 1'b1;
			wr_idx <= '0;
			cap.done <= 1'b0;
		end else if (active) begin
			wr_idx <= wr_idx + 1'b1;
			if (wr_idx == '1) begin
				active <= 1'b0;
				cap.done <= 1'b1;
			end
		end
	end

	// First word lands the edge after arm is seen
	always_ff @(posedge lb_clk) begin
		if (active)
			mem[wr_idx] <= adc_dout_i;
	end

	always_ff @(posedge lb_clk) begin
		word_q <= mem[cap.rd_index];
		chan_q <= cap.rd_chan;
	end

	assign cap.rd_sample = word_q[chan_q]; // Channel pick after the RAM

endmodule

`default_nettype wire

/* source/monitor_spi.sv */
// Mode 0 style, 32-bit frames MSB first; a start while busy is dropped
`default_nettype none

module monitor_spi (
	input logic lb_clk,
	input logic reset_i,
	spi_cmd_if.master spi,
	output logic sclk_o,
	output logic mosi_o,
	output logic ssb_o,
	input logic miso_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SHIFT,
		ST_FINISH
	} state_t;

	state_t state;
	logic [oscope_bus_pkg::SPI_HALF_W-1:0] half_cnt;
	logic [oscope_bus_pkg::SPI_BIT_W-1:0] bit_cnt;
	logic [oscope_bus_pkg::SPI_FRAME_BITS-1:0] sreg;
	logic miso_q;
	logic half_end;

	assign half_end = half_cnt == oscope_bus_pkg::SPI_HALF_W'(oscope_bus_pkg::SPI_HALF - 1);

	always_ff @(posedge lb_clk) begin
		if (reset_i) begin
			state <= ST_IDLE;
			sclk_o <= 1'b0;
			half_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (spi.start) begin
						state <= ST_SHIFT;
						half_cnt <= '0;
						bit_cnt <= '0;
						sclk_o <= 1'b0;
					end
				end
				ST_SHIFT: begin
					if (half_end) begin
						half_cnt <= '0;
						sclk_o <= ~sclk_o;
						if (sclk_o) begin // Falling edge ends a bit
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == oscope_bus_pkg::SPI_BIT_W'(oscope_bus_pkg::SPI_FRAME_BITS - 1))
								state <= ST_FINISH;
						end
					end else begin
						half_cnt <= half_cnt + 1'b1;
					end
				end
				ST_FINISH: begin
					// Hold ssb low for one more half period
					if (half_end) begin
						half_cnt <= '0;
						state <= ST_IDLE;
					end else begin
						half_cnt <= half_cnt + 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Frame out on the MSB, readback in at the LSB
	always_ff @(posedge lb_clk) begin
		if (state == ST_IDLE && spi.start)
			sreg <= {spi.addr, spi.data};
		else if (state == ST_SHIFT && half_end && sclk_o)
			sreg <= {sreg[oscope_bus_pkg::SPI_FRAME_BITS-2:0], miso_q};
		if (state == ST_SHIFT && half_end && !sclk_o)
			miso_q <= miso_i; // Rising sclk
		if (state == ST_FINISH && half_end)
			spi.rdbk <= sreg[15:0];
	end

	assign mosi_o = sreg[oscope_bus_pkg::SPI_FRAME_BITS-1];
	assign ssb_o = state == ST_IDLE;
	assign spi.ready = state == ST_IDLE;

endmodule

`default_nettype wire

/* source/oscope_top.sv */
// Everything runs on lb_clk; adc_dout_i must already be in that domain
`default_nettype none

module oscope_top (
	input logic lb_clk,
	input logic reset_i,
	input oscope_bus_pkg::lb_addr_t lb_addr_i,
	input logic lb_strobe_i,
	input logic lb_rd_i,
	input logic lb_write_i,
	input oscope_bus_pkg::lb_data_t lb_data_i,
	output oscope_bus_pkg::lb_data_t lb_din_o,
	output logic lb_rd_valid_o,
	input oscope_adc_pkg::adc_word_t adc_dout_i,
	output logic sclk_o,
	output logic mosi_o,
	output logic ssb_o,
	input logic miso_i
);

	spi_cmd_if spi_bus ();
	capture_if cap_bus ();

	// Bus front end
	lb_regs regs (
		.lb_clk        (lb_clk),
		.reset_i       (reset_i),
		.lb_addr_i     (lb_addr_i),
		.lb_strobe_i   (lb_strobe_i),
		.lb_rd_i       (lb_rd_i),
		.lb_write_i    (lb_write_i),
		.lb_data_i     (lb_data_i),
		.lb_din_o      (lb_din_o),
		.lb_rd_valid_o (lb_rd_valid_o),
		.spi           (spi_bus.regs),
		.cap           (cap_bus.regs)
	);

	// U2 digitizer data path
	capture_buffer capture (
		.lb_clk     (lb_clk),
		.reset_i    (reset_i),
		.adc_dout_i (adc_dout_i),
		.cap        (cap_bus.buffer)
	);

	// Housekeeping monitor, AMC7823 side
	monitor_spi monitor (
		.lb_clk  (lb_clk),
		.reset_i (reset_i),
		.spi     (spi_bus.master),
		.sclk_o  (sclk_o),
		.mosi_o  (mosi_o),
		.ssb_o   (ssb_o),
		.miso_i  (miso_i)
	);

endmodule

`default_nettype wire

/* test/oscope_top_tb.sv */
// Run from the project root so test/oscope_top_patterns.txt is found; a capture takes ~8200 cycles
`default_nettype none

module oscope_top_tb;

	localparam int BUF_DEPTH = 2 ** oscope_adc_pkg::BUF_AW;
	localparam int PAT_WORDS = 256;     // Four words per pattern line
	localparam int POLL_LIMIT = 5000;

	logic lb_clk;
	logic reset_i;
	oscope_bus_pkg::lb_addr_t lb_addr_i;
	logic lb_strobe_i;
	logic lb_rd_i;
	logic lb_write_i;
	oscope_bus_pkg::lb_data_t lb_data_i;
	oscope_bus_pkg::lb_data_t lb_din_o;
	logic lb_rd_valid_o;
	oscope_adc_pkg::adc_word_t adc_dout_i;
	logic sclk_o;
	logic mosi_o;
	logic ssb_o;
	logic miso_i;

	logic [31:0] pats [PAT_WORDS];
	logic [63:0] model_mem [BUF_DEPTH];  // Channel n in bits 16n+15 down to 16n
	int model_idx = BUF_DEPTH;          // Idle when out of range
	logic [31:0] lcg_state = 32'ha2b;
	logic [31:0] miso_word;
	logic [31:0] miso_sr;
	logic [31:0] mosi_sr;
	logic [31:0] last_frame;
	int mosi_bits;
	int frames;
	logic sclk_prev;
	logic ssb_prev = 1'b1;
	int errors;

	oscope_top dut (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	initial begin
		lb_clk = 1'b0;
		forever #50 lb_clk = ~lb_clk;
	end

	// Digitizer source plus capture model, keyed to the arm write on the bus
	always @(posedge lb_clk) begin : adc_model
		logic [31:0] hi;
		if (!reset_i) begin
			if (model_idx >= 0 && model_idx < BUF_DEPTH) begin
				model_mem[model_idx] = adc_dout_i;
				model_idx++;
			end else if (model_idx < 0) begin
				model_idx++;                // Arm pulse cycle
			end
			if (lb_strobe_i && lb_write_i && lb_addr_i == oscope_bus_pkg::ADDR_CTRL && lb_data_i[0])
				model_idx = -1;
		end
		hi = lcg_next(lcg_state);
		lcg_state = lcg_next(hi);
		adc_dout_i <= {hi, lcg_state};
	end

	// SPI slave, sees the pins one lb_clk late
	always @(posedge lb_clk) begin
		if (!reset_i) begin
			if (ssb_prev && !ssb_o) begin
				miso_sr = miso_word;
				mosi_bits = 0;
				miso_i <= miso_sr[31];
			end else if (!ssb_o && sclk_prev && !sclk_o) begin
				miso_sr = miso_sr << 1;
				miso_i <= miso_sr[31];
			end
			if (!ssb_o && !sclk_prev && sclk_o) begin
				mosi_sr = {mosi_sr[30:0], mosi_o}; // MSB arrives first
				mosi_bits++;
			end
			if (!ssb_prev && ssb_o) begin
				last_frame = mosi_sr;
				frames++;
				if (mosi_bits != oscope_bus_pkg::SPI_FRAME_BITS) begin
					$display("SPI frame had %0d sclk cycles instead of 32", mosi_bits);
					errors++;
				end
			end
		end
		sclk_prev = sclk_o;
		ssb_prev = ssb_o;
	end

	task automatic check_word(input string name, input oscope_bus_pkg::lb_data_t got,
			input oscope_bus_pkg::lb_data_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_sample(input string name, input oscope_adc_pkg::sample_t got,
			input oscope_adc_pkg::sample_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_field(input string name, input oscope_bus_pkg::spi_word_t got,
			input oscope_bus_pkg::spi_word_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic bus_write(input oscope_bus_pkg::lb_addr_t addr,
			input oscope_bus_pkg::lb_data_t data);
		@(posedge lb_clk);
		lb_addr_i <= addr;
		lb_data_i <= data;
		lb_strobe_i <= 1'b1;
		lb_write_i <= 1'b1;
		@(posedge lb_clk);
		lb_strobe_i <= 1'b0;
		lb_write_i <= 1'b0;
	endtask

	// Valid must be low, high, low on the three cycles after the accepting edge
	task automatic bus_read(input oscope_bus_pkg::lb_addr_t addr,
			output oscope_bus_pkg::lb_data_t data);
		logic v1;
		logic v2;
		logic v3;
		@(posedge lb_clk);
		lb_addr_i <= addr;
		lb_strobe_i <= 1'b1;
		lb_rd_i <= 1'b1;
		@(posedge lb_clk);
		lb_strobe_i <= 1'b0;
		lb_rd_i <= 1'b0;
		@(negedge lb_clk);
		v1 = lb_rd_valid_o;
		@(negedge lb_clk);
		v2 = lb_rd_valid_o;
		data = lb_din_o;
		@(negedge lb_clk);
		v3 = lb_rd_valid_o;
		if (v1 !== 1'b0 || v2 !== 1'b1 || v3 !== 1'b0) begin
			$display("lb_rd_valid_o did not pulse 2 cycles after the read at %0t", $time);
			errors++;
		end
	endtask

	task automatic poll_status(input oscope_bus_pkg::lb_addr_t addr, input int bit_no,
			input logic value, output logic ok);
		oscope_bus_pkg::lb_data_t rd;
		ok = 1'b0;
		for (int n = 0; n < POLL_LIMIT && !ok; n++) begin
			bus_read(addr, rd);
			ok = rd[bit_no] === value;
		end
		if (!ok) begin
			$display("timed out waiting for status bit %0d to read %0b", bit_no, value);
			errors++;
		end
	endtask

	initial begin : run
		oscope_bus_pkg::lb_data_t rd;
		oscope_bus_pkg::lb_addr_t baddr;
		oscope_adc_pkg::buf_addr_t idx;
		oscope_adc_pkg::chan_sel_t ch;
		logic ok;
		int tests;
		int base;
		reset_i = 1'b1;
		lb_addr_i = '0;
		lb_strobe_i = 1'b0;
		lb_rd_i = 1'b0;
		lb_write_i = 1'b0;
		lb_data_i = '0;
		adc_dout_i = '0;
		miso_i = 1'b0;
		miso_word = '0;
		errors = 0;
		frames = 0;
		tests = 0;
		base = 0;
		ok = 1'b1;
		$readmemh("test/oscope_top_patterns.txt", pats);
		repeat (8) @(posedge lb_clk);
		reset_i <= 1'b0;
		for (int i = 0; i + 3 < PAT_WORDS && pats[i] != 0 && ok; i += 4) begin
			case (pats[i])
				1: bus_write(pats[i+1][23:0], pats[i+2]);
				2: begin
					bus_read(pats[i+1][23:0], rd);
					check_word("lb_din_o", rd, pats[i+3]);
				end
				3: poll_status(pats[i+1][23:0], pats[i+2], pats[i+3][0], ok);
				4: miso_word = pats[i+2];
				5: begin
					idx = pats[i+1][oscope_adc_pkg::BUF_AW-1:0];
					ch = pats[i+2][1:0];
					baddr = '0;
					baddr[oscope_bus_pkg::BUF_WINDOW_BIT] = 1'b1;
					baddr[oscope_adc_pkg::BUF_AW+1:2] = idx;
					baddr[1:0] = ch;
					bus_read(baddr, rd);
					check_sample("lb_din_o sample", rd[15:0], model_mem[idx][ch*16 +: 16]);
				end
				6: begin
					check_field("spi frame address", last_frame[31:16], pats[i+2][31:16]);
					check_field("spi frame data", last_frame[15:0], pats[i+2][15:0]);
					check_word("spi frame count", frames, pats[i+3]);
				end
				7: begin
					$display("test %0d finished with %0d errors", pats[i+2], errors - base);
					tests++;
					base = errors;
				end
				default: begin
					$display("unknown pattern op %0h at word %0d", pats[i], i);
					errors++;
				end
			endcase
		end
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* test/oscope_top_patterns.txt */
// op addr data expect, all hex; 1 write, 2 read and compare, 3 poll status bit (data) for expect
// 4 set miso word, 5 buffer sample (addr index, data channel), 6 spi frame and count, 7 end of test
2 000002 00000000 00000002
7 000000 00000001 00000000
1 000001 00000001 00000000
3 000002 00000000 00000001
5 000000 00000000 00000000
5 000001 00000003 00000000
5 000fa3 00000002 00000000
5 001fff 00000001 00000000
7 000000 00000002 00000000
4 000000 a5a51234 00000000
1 000003 00c35a0f 00000000
1 000003 11112222 00000000
3 000002 00000001 00000001
6 000000 00c35a0f 00000001
2 000004 00000000 00001234
7 000000 00000003 00000000
2 000000 00000000 00000000
2 7fffff 00000000 00000000
1 000001 00000001 00000000
2 000002 00000000 00000002
3 000002 00000000 00000001
5 000002 00000000 00000000
5 001fff 00000003 00000000
7 000000 00000004 00000000
0 000000 00000000 00000000

/* oscope_top.f */
source/oscope_bus_pkg.sv
source/oscope_adc_pkg.sv
source/oscope_ifs.sv
source/lb_regs.sv
source/capture_buffer.sv
source/monitor_spi.sv
source/oscope_top.sv
test/oscope_top_tb.sv

/* Bender.yml */
package:
  name: oscope_top

sources:
  - source/oscope_bus_pkg.sv
  - source/oscope_adc_pkg.sv
  - source/oscope_ifs.sv
  - source/lb_regs.sv
  - source/capture_buffer.sv
  - source/monitor_spi.sv
  - source/oscope_top.sv
  - target: test
    files:
      - test/oscope_top_tb.sv
